/* logic/filt_cfg_pkg.sv */
package filt_cfg_pkg;

	// Lane buffer geometry
	localparam int addr_w = 9;          // 512 words per lane
	localparam int data_w = 64;         // Snooper and forwarder word width
	localparam int len_w  = addr_w + 1; // Room for a completely full buffer

	typedef logic [addr_w-1:0] pkt_addr_t;
	typedef logic [data_w-1:0] pkt_data_t;
	typedef logic [len_w-1:0]  pkt_len_t;

	// Snooper side with one copy per lane after the splitter
	typedef struct packed {
		pkt_addr_t wr_addr;
		pkt_data_t wr_data;
		logic      wr_en;
		logic      done;     // One-cycle pulse ends the packet
	} snoop_req_t;

	// Forwarder side with one copy per lane after the combiner
	typedef struct packed {
		pkt_addr_t rd_addr;
		logic      rd_en;    // Data shows up on the following cycle
		logic      done;     // One-cycle pulse frees the lane
	} fwd_req_t;

	// What every lane reports back
	typedef struct packed {
		pkt_data_t rd_data;   // Registered read data
		pkt_len_t  len;       // Valid while full
		logic      full;      // Holds a finished packet
		logic      accepting; // Running and empty
	} lane_rsp_t;

endpackage

/* logic/filt_reg_pkg.sv */
package filt_reg_pkg;

	localparam int reg_addr_w = 12; // AXI4-Lite byte address

	// Register map
	localparam logic [reg_addr_w-1:0] ctrl_offset   = 12'h000; // Bit 0 start
	localparam logic [reg_addr_w-1:0] status_offset = 12'h004; // Bits 15:0 drop count

	// Response codes
	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	typedef struct packed {
		logic [reg_addr_w-1:0] awaddr;
		logic                  awvalid;
		logic [31:0]           wdata;
		logic [3:0]            wstrb;
		logic                  wvalid;
		logic                  bready;
		logic [reg_addr_w-1:0] araddr;
		logic                  arvalid;
		logic                  rready;
	} axil_req_t;

	typedef struct packed {
		logic        awready;
		logic        wready;
		logic [1:0]  bresp;
		logic        bvalid;
		logic        arready;
		logic [31:0] rdata;
		logic [1:0]  rresp;
		logic        rvalid;
	} axil_rsp_t;

endpackage

/* logic/filt_regs.sv */
module filt_regs (
	input  logic                    axi_aclk,
	input  logic                    rst_n,
	input  filt_reg_pkg::axil_req_t axil_req,
	output filt_reg_pkg::axil_rsp_t axil_rsp,
	input  logic                    drop,  // One pulse per dropped packet
	output logic                    start  // Runs the lanes
);

	logic        wr_hs;     // AW and W taken in the same cycle
	logic        rd_hs;     // AR taken
	logic        wr_ctrl;
	logic        wr_status;
	logic        rd_ctrl;
	logic        rd_status;
	logic        bvalid;
	logic        rvalid;
	logic [1:0]  bresp;
	logic [1:0]  rresp;
	logic [31:0] rdata;
	logic [15:0] drop_cnt;  // Saturates at all ones

	// Address and data are only taken together, and only with no response pending
	assign wr_hs = axil_req.awvalid && axil_req.wvalid && !bvalid;
	assign rd_hs = axil_req.arvalid && !rvalid;

	// Address decode
	assign wr_ctrl   = (axil_req.awaddr == filt_reg_pkg::ctrl_offset);
	assign wr_status = (axil_req.awaddr == filt_reg_pkg::status_offset);
	assign rd_ctrl   = (axil_req.araddr == filt_reg_pkg::ctrl_offset);
	assign rd_status = (axil_req.araddr == filt_reg_pkg::status_offset);

	always_ff @(posedge axi_aclk) begin
		if (!rst_n) begin
			bvalid <= 1'b0;
		end else if (wr_hs) begin
			bvalid <= 1'b1;
		end else if (axil_req.bready) begin
			bvalid <= 1'b0; // Response consumed
		end
	end

	always_ff @(posedge axi_aclk) begin
		if (wr_hs) begin
			// Status writes are harmless but legal
			bresp <= (wr_ctrl || wr_status) ? filt_reg_pkg::resp_okay
				: filt_reg_pkg::resp_slverr;
		end
	end

	// Control register in byte lane 0 only
	always_ff @(posedge axi_aclk) begin
		if (!rst_n) begin
			start <= 1'b0;
		end else if (wr_hs && wr_ctrl && axil_req.wstrb[0]) begin
			start <= axil_req.wdata[0];
		end
	end

	always_ff @(posedge axi_aclk) begin
		if (!rst_n) begin
			rvalid <= 1'b0;
		end else if (rd_hs) begin
			rvalid <= 1'b1;
		end else if (axil_req.rready) begin
			rvalid <= 1'b0;
		end
	end

	// Read data is sampled at the AR handshake
	always_ff @(posedge axi_aclk) begin
		if (rd_hs) begin
			rresp <= filt_reg_pkg::resp_okay;
			if (rd_ctrl) begin
				rdata <= {31'b0, start};
			end else if (rd_status) begin
				rdata <= {16'b0, drop_cnt};
			end else begin
				rdata <= '0;                       // Unmapped
				rresp <= filt_reg_pkg::resp_slverr;
			end
		end
	end

	// Drop counter cleared by an accepted status read
	always_ff @(posedge axi_aclk) begin
		if (!rst_n) begin
			drop_cnt <= '0;
		end else if (rd_hs && rd_status) begin
			drop_cnt <= drop ? 16'd1 : 16'd0; // Same-cycle drop is not lost
		end else if (drop && drop_cnt != 16'hffff) begin
			drop_cnt <= drop_cnt + 1'b1;
		end
	end

	always_comb begin
		axil_rsp.awready = wr_hs; // Both readies pulse together
		axil_rsp.wready  = wr_hs;
		axil_rsp.bresp   = bresp;
		axil_rsp.bvalid  = bvalid;
		axil_rsp.arready = rd_hs;
		axil_rsp.rdata   = rdata;
		axil_rsp.rresp   = rresp;
		axil_rsp.rvalid  = rvalid;
	end

endmodule

/* logic/snoop_split.sv */
module snoop_split #(
	parameter int n_lanes = 4 // Power of two, 2 or more
) (
	input  logic                     axi_aclk,
	input  logic                     rst_n,
	input  filt_cfg_pkg::snoop_req_t snoop_req,
	input  logic [n_lanes-1:0]       lane_accepting,
	output filt_cfg_pkg::snoop_req_t lane_req [n_lanes],
	output logic                     ready_for_snooper,
	output logic                     drop               // Done with nowhere to go
);

	localparam int ptr_w = $clog2(n_lanes);

	logic [ptr_w-1:0] wr_ptr;   // Lane that gets the next packet
	logic             cur_ok;   // Pointed lane can take a packet
	logic             accept;   // Packet handed over this cycle

	assign cur_ok = lane_accepting[wr_ptr];
	assign accept = snoop_req.done && cur_ok;

	// Snooper sees the pointed lane only
	assign ready_for_snooper = cur_ok;
	assign drop              = snoop_req.done && !cur_ok;

	// Round robin wraps on its own since n_lanes is a power of two
	always_ff @(posedge axi_aclk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
		end else if (accept) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	// Address and data go everywhere but strobes only to the pointed lane
	always_comb begin
		for (int i = 0; i < n_lanes; i++) begin
			lane_req[i]         = snoop_req;
			lane_req[i].wr_en   = 1'b0;
			lane_req[i].done    = 1'b0;
			if (wr_ptr == ptr_w'(i) && cur_ok) begin
				lane_req[i].wr_en = snoop_req.wr_en;
				lane_req[i].done  = snoop_req.done;
			end
		end
	end

endmodule

/* logic/packet_lane.sv */
module packet_lane (
	input  logic                     axi_aclk,
	input  logic                     rst_n,
	input  logic                     start,  // Low empties the lane
	input  filt_cfg_pkg::snoop_req_t wr,
	input  filt_cfg_pkg::fwd_req_t   rd,
	output filt_cfg_pkg::lane_rsp_t  rsp
);

	filt_cfg_pkg::pkt_data_t mem [2**filt_cfg_pkg::addr_w];

	filt_cfg_pkg::pkt_data_t rd_q;    // Registered read port
	filt_cfg_pkg::pkt_len_t  len_q;   // Captured on done
	filt_cfg_pkg::pkt_addr_t hi_addr; // Highest address written so far
	filt_cfg_pkg::pkt_addr_t hi_nxt;  // Including this cycle's write
	logic                    full;

	// Done may land together with the last word
	assign hi_nxt = (wr.wr_en && wr.wr_addr > hi_addr) ? wr.wr_addr : hi_addr;

	// Packet buffer
	always_ff @(posedge axi_aclk) begin
		if (wr.wr_en) begin
			mem[wr.wr_addr] <= wr.wr_data;
		end
		if (rd.rd_en) begin
			rd_q <= mem[rd.rd_addr]; // One cycle latency
		end
	end

	always_ff @(posedge axi_aclk) begin
		if (!rst_n) begin
			full    <= 1'b0;
			hi_addr <= '0;
		end else if (!start) begin
			full    <= 1'b0; // Stopped lanes hold nothing
			hi_addr <= '0;
		end else if (wr.done) begin
			full    <= 1'b1;
			hi_addr <= '0;   // Ready for the next packet
		end else begin
			if (rd.done) begin
				full <= 1'b0;
			end
			hi_addr <= hi_nxt;
		end
	end

	// Length is highest address plus one
	always_ff @(posedge axi_aclk) begin
		if (wr.done) begin
			len_q <= filt_cfg_pkg::pkt_len_t'(hi_nxt) + 1'b1;
		end
	end

	always_comb begin
		rsp.rd_data   = rd_q;
		rsp.len       = len_q;
		rsp.full      = full;
		rsp.accepting = start && !full;
	end

endmodule

/* logic/fwd_combine.sv */
module fwd_combine #(
	parameter int n_lanes = 4 // Power of two, 2 or more
) (
	input  logic                    axi_aclk,
	input  logic                    rst_n,
	input  filt_cfg_pkg::fwd_req_t  fwd_req,
	input  filt_cfg_pkg::lane_rsp_t lane_rsp [n_lanes],
	output filt_cfg_pkg::fwd_req_t  lane_rd [n_lanes],
	output filt_cfg_pkg::pkt_data_t forwarder_rd_data,
	output filt_cfg_pkg::pkt_len_t  len_to_forwarder,
	output logic                    ready_for_forwarder
);

	localparam int ptr_w = $clog2(n_lanes);

	logic [ptr_w-1:0] rd_ptr;   // Lane being served
	logic [ptr_w-1:0] rd_ptr_q; // Lane that answered last cycle's read
	logic             cur_full;

	// Same rotation as the splitter keeps packets in arrival order
	assign cur_full = lane_rsp[rd_ptr].full;

	always_ff @(posedge axi_aclk) begin
		if (!rst_n) begin
			rd_ptr   <= '0;
			rd_ptr_q <= '0;
		end else begin
			rd_ptr_q <= rd_ptr;
			if (fwd_req.done && cur_full) begin
				rd_ptr <= rd_ptr + 1'b1; // Moves with the lane emptying
			end
		end
	end

	// Strobes to the pointed lane only, and only while it holds a packet
	always_comb begin
		for (int i = 0; i < n_lanes; i++) begin
			lane_rd[i]       = fwd_req;
			lane_rd[i].rd_en = 1'b0;
			lane_rd[i].done  = 1'b0;
			if (rd_ptr == ptr_w'(i) && cur_full) begin
				lane_rd[i].rd_en = fwd_req.rd_en;
				lane_rd[i].done  = fwd_req.done;
			end
		end
	end

	assign ready_for_forwarder = cur_full;
	assign len_to_forwarder    = lane_rsp[rd_ptr].len;
	// Delayed pointer so a read right before done still returns the old lane
	assign forwarder_rd_data   = lane_rsp[rd_ptr_q].rd_data;

endmodule

/* logic/packet_filter_top.sv */
module packet_filter_top #(
	parameter int n_lanes = 4 // Power of two, 2 or more
) (
	input  logic                     axi_aclk,
	input  logic                     rst_n,

	// Register access
	input  filt_reg_pkg::axil_req_t  axil_req,
	output filt_reg_pkg::axil_rsp_t  axil_rsp,

	// Snooper
	input  filt_cfg_pkg::snoop_req_t snoop_req,
	output logic                     ready_for_snooper,

	// Forwarder
	input  filt_cfg_pkg::fwd_req_t   fwd_req,
	output filt_cfg_pkg::pkt_data_t  forwarder_rd_data,
	output filt_cfg_pkg::pkt_len_t   len_to_forwarder,
	output logic                     ready_for_forwarder
);

	logic                     start;                   // Control bit 0
	logic                     drop;                    // Splitter to counter
	logic [n_lanes-1:0]       lane_accepting;
	filt_cfg_pkg::snoop_req_t lane_wr  [n_lanes];      // Per-lane write side
	filt_cfg_pkg::fwd_req_t   lane_rd  [n_lanes];      // Per-lane read side
	filt_cfg_pkg::lane_rsp_t  lane_rsp [n_lanes];

	filt_regs u_regs (
		.axi_aclk (axi_aclk),
		.rst_n    (rst_n),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp),
		.drop     (drop),
		.start    (start)
	);

	snoop_split #(
		.n_lanes (n_lanes)
	) u_split (
		.axi_aclk          (axi_aclk),
		.rst_n             (rst_n),
		.snoop_req         (snoop_req),
		.lane_accepting    (lane_accepting),
		.lane_req          (lane_wr),
		.ready_for_snooper (ready_for_snooper),
		.drop              (drop)
	);

	// Lanes side by side
	for (genvar i = 0; i < n_lanes; i++) begin : g_lane
		packet_lane u_lane (
			.axi_aclk (axi_aclk),
			.rst_n    (rst_n),
			.start    (start),
			.wr       (lane_wr[i]),
			.rd       (lane_rd[i]),
			.rsp      (lane_rsp[i])
		);

		assign lane_accepting[i] = lane_rsp[i].accepting; // Flattened for the splitter
	end

	fwd_combine #(
		.n_lanes (n_lanes)
	) u_combine (
		.axi_aclk            (axi_aclk),
		.rst_n               (rst_n),
		.fwd_req             (fwd_req),
		.lane_rsp            (lane_rsp),
		.lane_rd             (lane_rd),
		.forwarder_rd_data   (forwarder_rd_data),
		.len_to_forwarder    (len_to_forwarder),
		.ready_for_forwarder (ready_for_forwarder)
	);

endmodule

/* test/tb_packet_filter.sv */
module tb_packet_filter;

	localparam int n_lanes     = 4;
	localparam int max_pkts    = 40;
	localparam int max_words   = 32;
	localparam int cycle_limit = max_pkts * (max_words + 40) + 2000;

	// What the reference model predicts
	typedef struct packed {
		logic [31:0]            head;   // Id of the next packet to leave
		filt_cfg_pkg::pkt_len_t len;    // Its length in words
		logic [31:0]            status; // Status register value
	} expect_t;

	logic                     axi_aclk = 1'b0;
	logic                     rst_n;
	filt_reg_pkg::axil_req_t  axil_req;
	filt_reg_pkg::axil_rsp_t  axil_rsp;
	filt_cfg_pkg::snoop_req_t snoop_req;
	logic                     ready_for_snooper;
	filt_cfg_pkg::fwd_req_t   fwd_req;
	filt_cfg_pkg::pkt_data_t  forwarder_rd_data;
	filt_cfg_pkg::pkt_len_t   len_to_forwarder;
	logic                     ready_for_forwarder;

	filt_cfg_pkg::pkt_data_t pkt_words [max_pkts][max_words];
	filt_cfg_pkg::pkt_len_t  pkt_len   [max_pkts];
	int unsigned accepted_q [$];    // Ids buffered in lanes, oldest first
	int unsigned drop_tally = 0;    // Drops since the last status read
	int unsigned n_sent     = 0;
	int unsigned cycles     = 0;
	logic        fwd_enable = 1'b0; // Forwarder drains only while set

	packet_filter_top #(
		.n_lanes (n_lanes)
	) u_dut (
		.axi_aclk            (axi_aclk),
		.rst_n               (rst_n),
		.axil_req            (axil_req),
		.axil_rsp            (axil_rsp),
		.snoop_req           (snoop_req),
		.ready_for_snooper   (ready_for_snooper),
		.fwd_req             (fwd_req),
		.forwarder_rd_data   (forwarder_rd_data),
		.len_to_forwarder    (len_to_forwarder),
		.ready_for_forwarder (ready_for_forwarder)
	);

	always #4 axi_aclk = ~axi_aclk;

	always @(posedge axi_aclk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, a handshake never completed", cycles);
			abort_run();
		end
	end

	task automatic abort_run();
		$display("RESULT: FAIL");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic expect_true(input logic cond, input string msg);
		if (!cond) begin
			$display("%s", msg);
			abort_run();
		end
	endtask

	task automatic check_word(input string what, input filt_cfg_pkg::pkt_data_t got,
			input filt_cfg_pkg::pkt_data_t exp);
		if (got !== exp) begin
			$display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_len(input filt_cfg_pkg::pkt_len_t got,
			input filt_cfg_pkg::pkt_len_t exp);
		if (got !== exp) begin
			$display("error at %0t: len_to_forwarder is %0d, expected %0d", $time, got, exp);
			abort_run();
		end
	endtask

	task automatic check_reg(input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("error at %0t: register read %h, expected %h", $time, got, exp);
			abort_run();
		end
	endtask

	task automatic check_resp(input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			$display("error at %0t: AXI response %0d, expected %0d", $time, got, exp);
			abort_run();
		end
	endtask

	// Head of the arrival queue leaves next and status saturates at 16 bits
	function automatic expect_t predict(input int unsigned q[$], input int unsigned drops);
		expect_t e;
		e.head   = (q.size() > 0) ? q[0] : 0;
		e.len    = (q.size() > 0) ? pkt_len[q[0]] : '0;
		e.status = (drops > 65535) ? 32'h0000_ffff : drops;
		return e;
	endfunction

	// Entered and left just after a rising edge
	task automatic reg_write(input logic [11:0] addr, input logic [31:0] data,
			input logic [1:0] exp_resp);
		axil_req.awaddr  <= addr;
		axil_req.wdata   <= data;
		axil_req.wstrb   <= 4'hf;
		axil_req.awvalid <= 1'b1;
		axil_req.wvalid  <= 1'b1;
		do @(negedge axi_aclk); while (!axil_rsp.awready);
		expect_true(axil_rsp.wready, "wready did not rise together with awready");
		@(posedge axi_aclk);
		axil_req.awvalid <= 1'b0;
		axil_req.wvalid  <= 1'b0;
		do @(negedge axi_aclk); while (!axil_rsp.bvalid);
		check_resp(axil_rsp.bresp, exp_resp);
		@(posedge axi_aclk);    // bready is always high
	endtask

	task automatic reg_read(input logic [11:0] addr, input logic [31:0] exp_data,
			input logic [1:0] exp_resp);
		axil_req.araddr  <= addr;
		axil_req.arvalid <= 1'b1;
		do @(negedge axi_aclk); while (!axil_rsp.arready);
		@(posedge axi_aclk);
		axil_req.arvalid <= 1'b0;
		do @(negedge axi_aclk); while (!axil_rsp.rvalid);
		check_reg(axil_rsp.rdata, exp_data);
		check_resp(axil_rsp.rresp, exp_resp);
		@(posedge axi_aclk);
	endtask

	task automatic status_read();
		expect_t e;
		e = predict(accepted_q, drop_tally);
		reg_read(filt_reg_pkg::status_offset, e.status, filt_reg_pkg::resp_okay);
		drop_tally = 0; // Read clears the count
	endtask

	// Random length and data with done on a cycle of its own
	task automatic send_packet(input logic expect_accept);
		int unsigned len;
		int unsigned id;
		id          = n_sent;
		len         = 1 + ($urandom % max_words);
		pkt_len[id] = filt_cfg_pkg::pkt_len_t'(len); // Highest address plus one
		for (int i = 0; i < len; i++) begin
			pkt_words[id][i] = {$urandom, $urandom};
			snoop_req.wr_addr <= filt_cfg_pkg::pkt_addr_t'(i);
			snoop_req.wr_data <= pkt_words[id][i];
			snoop_req.wr_en   <= 1'b1;
			@(posedge axi_aclk);
		end
		snoop_req.wr_en <= 1'b0;
		snoop_req.done  <= 1'b1;
		@(posedge axi_aclk);
		snoop_req.done <= 1'b0;
		if (expect_accept) begin
			accepted_q.push_back(id);
		end else begin
			drop_tally++;
		end
		n_sent++;
	endtask

	task automatic send_when_ready();
		do @(negedge axi_aclk); while (!ready_for_snooper);
		@(posedge axi_aclk);
		send_packet(1'b1);   // A lane that was offered stays open until done
	endtask

	task automatic wait_drained();
		do @(negedge axi_aclk); while (accepted_q.size() != 0);
		@(posedge axi_aclk);
	endtask

	// Forwarder and checker with pipelined reads of one cycle latency
	initial begin : forwarder
		expect_t e;
		forever begin
			do @(negedge axi_aclk); while (!(fwd_enable && ready_for_forwarder));
			expect_true(accepted_q.size() > 0,
				"Forwarder was offered a packet nobody sent");
			e = predict(accepted_q, drop_tally);
			check_len(len_to_forwarder, e.len);
			@(posedge axi_aclk);
			for (int i = 0; i < e.len; i++) begin
				fwd_req.rd_addr <= filt_cfg_pkg::pkt_addr_t'(i);
				fwd_req.rd_en   <= 1'b1;
				@(negedge axi_aclk);
				if (i > 0) begin
					check_word("forwarded word", forwarder_rd_data,
						pkt_words[e.head][i-1]);
				end
				@(posedge axi_aclk);
			end
			fwd_req.rd_en <= 1'b0;
			fwd_req.done  <= 1'b1;
			@(negedge axi_aclk);
			check_word("last forwarded word", forwarder_rd_data,
				pkt_words[e.head][e.len-1]);
			@(posedge axi_aclk);
			fwd_req.done <= 1'b0;
			void'(accepted_q.pop_front());
		end
	end

	initial begin : stimulus
		void'($urandom(32'hedc9_9962));
		rst_n     = 1'b0;
		axil_req  = '0;
		snoop_req = '0;
		fwd_req   = '0;
		axil_req.bready = 1'b1;
		axil_req.rready = 1'b1;
		repeat (2) @(posedge axi_aclk);
		rst_n <= 1'b1;
		@(posedge axi_aclk);

		// Quiet after reset
		@(negedge axi_aclk);
		expect_true(!ready_for_snooper && !ready_for_forwarder,
			"A ready output is high after reset");
		expect_true(!axil_rsp.bvalid && !axil_rsp.rvalid,
			"An AXI response is pending after reset");
		@(posedge axi_aclk);
		reg_read(filt_reg_pkg::ctrl_offset, 32'h0, filt_reg_pkg::resp_okay);

		// Stopped lanes drop everything
		repeat (3) send_packet(1'b0);
		status_read();
		status_read();

		// Unmapped space and the read-only status word
		reg_write(12'h010, 32'h1, filt_reg_pkg::resp_slverr);
		reg_read(12'h010, 32'h0, filt_reg_pkg::resp_slverr);
		reg_write(filt_reg_pkg::status_offset, 32'hffff_ffff, filt_reg_pkg::resp_okay);
		status_read();
		reg_read(filt_reg_pkg::ctrl_offset, 32'h0, filt_reg_pkg::resp_okay);

		// Fill every lane, then overflow
		reg_write(filt_reg_pkg::ctrl_offset, 32'h1, filt_reg_pkg::resp_okay);
		repeat (n_lanes) send_when_ready();
		@(negedge axi_aclk);
		expect_true(!ready_for_snooper, "Snooper still offered a lane with all lanes full");
		@(posedge axi_aclk);
		repeat (2) send_packet(1'b0);
		status_read();

		// Drain while the snooper keeps going
		fwd_enable = 1'b1;
		repeat (20) send_when_ready();
		wait_drained();

		// Stop with packets buffered, then restart
		fwd_enable = 1'b0;
		repeat (n_lanes) send_when_ready();
		reg_write(filt_reg_pkg::ctrl_offset, 32'h0, filt_reg_pkg::resp_okay);
		@(negedge axi_aclk);
		expect_true(!ready_for_forwarder, "Forwarder still offered a packet after stop");
		expect_true(!ready_for_snooper, "Snooper still offered a lane after stop");
		@(posedge axi_aclk);
		accepted_q.delete();    // Lanes were emptied
		reg_write(filt_reg_pkg::ctrl_offset, 32'h1, filt_reg_pkg::resp_okay);
		fwd_enable = 1'b1;
		repeat (6) send_when_ready();
		wait_drained();
		status_read();

		$display("RESULT: PASS");
		$finish;
	end

endmodule

/* tb.f */
logic/filt_cfg_pkg.sv
logic/filt_reg_pkg.sv
logic/filt_regs.sv
logic/snoop_split.sv
logic/packet_lane.sv
logic/fwd_combine.sv
logic/packet_filter_top.sv
test/tb_packet_filter.sv

/* run_sim.sh */
#!/bin/sh
verilator --binary --timing -Wno-fatal --top-module tb_packet_filter -f tb.f -o sim_tb \
	|| { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "Simulation gave no result"; exit 1; }
exit 0
